//--- phy_pkg.sv
package phy_pkg;

    // flit geometry
    localparam int BYTES_PER_FLIT = 5;
    localparam int FLIT_W         = 8 * BYTES_PER_FLIT;
    localparam int SYM_W          = 10;
    localparam int ENC_FLIT_W     = SYM_W * BYTES_PER_FLIT;

    // encoded byte 3 rides along as metadata in two-symbol control words
    localparam int META_BYTE      = 3;

    // request kind, anything above DATA_SEL is a no-op
    typedef enum logic [3:0] {
        START_PACKET_SEL   = 4'd0,
        END_PACKET_SEL     = 4'd1,
        RESEND_PACKET0_SEL = 4'd2,
        RESEND_PACKET1_SEL = 4'd3,
        RESEND_PACKET2_SEL = 4'd4,
        RESEND_PACKET3_SEL = 4'd5,
        ACK_SEL            = 4'd6,
        NACK_SEL           = 4'd7,
        DATA_SEL           = 4'd8
    } comma_sel_t;

    // number of symbols the serializer sends for one word
    typedef enum logic [1:0] {
        SELECT_COMMA_1_FLIT = 2'd0,
        SELECT_COMMA_2_FLIT = 2'd1,
        SELECT_COMMA_DATA   = 2'd2
    } comma_length_sel_t;

    // K28.x symbols, negative disparity, bit a in the msb
    typedef enum logic [9:0] {
        // K28.1
        START_COMMA          = 10'b001111_1001,
        // K28.5
        END_COMMA            = 10'b001111_1010,
        // K28.0
        RESEND_PACKET0_COMMA = 10'b001111_0100,
        // K28.2
        RESEND_PACKET1_COMMA = 10'b001111_0101,
        // K28.3
        RESEND_PACKET2_COMMA = 10'b001111_0011,
        // K28.4
        RESEND_PACKET3_COMMA = 10'b001111_0010,
        // K28.6
        ACK_COMMA            = 10'b001111_0110,
        // K28.7
        NACK_COMMA           = 10'b001111_1000
    } comma_t;

    // one 50-bit word, either five data symbols or a control word
    typedef union packed {
        // sym[4] is the msb symbol and goes out first
        logic [BYTES_PER_FLIT-1:0][SYM_W-1:0] sym;
        struct packed {
            comma_t                          comma;
            // lines up with sym[META_BYTE]
            logic [SYM_W-1:0]                meta_data;
            logic [ENC_FLIT_W-2*SYM_W-1:0]   pad;
        } ctrl;
    } flit_enc_t;

endpackage

//--- enc_8b10b.sv
`timescale 1ns/1ns

module enc_8b10b (
    input  logic [7:0] data_in,
    output logic [9:0] data_out
);

    // EDCBA part
    logic [4:0] x5;
    // HGF part
    logic [2:0] y3;
    // abcdei, a in the msb
    logic [5:0] code6;
    // fghj, f in the msb
    logic [3:0] code4;
    // disparity after the 6b sub-block
    logic       rd_pos;
    logic       use_alt7;

    assign x5 = data_in[4:0];
    assign y3 = data_in[7:5];

    // 5b/6b, column for negative running disparity
    always_comb begin
        case (x5)
            5'd0:    code6 = 6'b100111;
            5'd1:    code6 = 6'b011101;
            5'd2:    code6 = 6'b101101;
            5'd3:    code6 = 6'b110001;
            5'd4:    code6 = 6'b110101;
            5'd5:    code6 = 6'b101001;
            5'd6:    code6 = 6'b011001;
            5'd7:    code6 = 6'b111000;
            5'd8:    code6 = 6'b111001;
            5'd9:    code6 = 6'b100101;
            5'd10:   code6 = 6'b010101;
            5'd11:   code6 = 6'b110100;
            5'd12:   code6 = 6'b001101;
            5'd13:   code6 = 6'b101100;
            5'd14:   code6 = 6'b011100;
            5'd15:   code6 = 6'b010111;
            5'd16:   code6 = 6'b011011;
            5'd17:   code6 = 6'b100011;
            5'd18:   code6 = 6'b010011;
            5'd19:   code6 = 6'b110010;
            5'd20:   code6 = 6'b001011;
            5'd21:   code6 = 6'b101010;
            5'd22:   code6 = 6'b011010;
            5'd23:   code6 = 6'b111010;
            5'd24:   code6 = 6'b110011;
            5'd25:   code6 = 6'b100110;
            5'd26:   code6 = 6'b010110;
            5'd27:   code6 = 6'b110110;
            5'd28:   code6 = 6'b001110;
            5'd29:   code6 = 6'b101110;
            5'd30:   code6 = 6'b011110;
            default: code6 = 6'b101011;
        endcase
    end

    // an unbalanced 6b code here always has four ones, so rd goes positive
    assign rd_pos = ($countones(code6) > 3);

    // D.x.A7 keeps a run of five equal bits from looking like a comma
    assign use_alt7 = rd_pos ? (x5 == 5'd11 || x5 == 5'd13 || x5 == 5'd14)
                             : (x5 == 5'd17 || x5 == 5'd18 || x5 == 5'd20);

    // 3b/4b, column picked by the disparity left by the 6b code
    always_comb begin
        case (y3)
            3'd0:    code4 = rd_pos ? 4'b0100 : 4'b1011;
            3'd1:    code4 = 4'b1001;
            3'd2:    code4 = 4'b0101;
            3'd3:    code4 = rd_pos ? 4'b0011 : 4'b1100;
            3'd4:    code4 = rd_pos ? 4'b0010 : 4'b1101;
            3'd5:    code4 = 4'b1010;
            3'd6:    code4 = 4'b0110;
            default: begin
                if (use_alt7) begin
                    code4 = rd_pos ? 4'b1000 : 4'b0111;
                end else begin
                    code4 = rd_pos ? 4'b0001 : 4'b1110;
                end
            end
        endcase
    end

    // abcdei fghj, a goes on the line first
    assign data_out = {code6, code4};

endmodule

//--- wrap_enc_8b_10b_if.sv
`timescale 1ns/1ns

interface wrap_enc_8b_10b_if import phy_pkg::*; ();

    // framer to encoder
    logic              start;
    logic [FLIT_W-1:0] flit;
    comma_sel_t        comma_sel;

    // encoder to serializer
    logic              start_out;
    flit_enc_t         flit_out;
    comma_length_sel_t comma_length_sel_out;

    modport framer (
        output start,
        output flit,
        output comma_sel
    );

    modport enc (
        input  start,
        input  flit,
        input  comma_sel,
        output start_out,
        output flit_out,
        output comma_length_sel_out
    );

    // start is only looked at for the ready level
    modport ser (
        input  start,
        input  start_out,
        input  flit_out,
        input  comma_length_sel_out
    );

endinterface

//--- tx_flit_framer.sv
`timescale 1ns/1ns

module tx_flit_framer import phy_pkg::*; (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                req_start,
    input  logic [3:0]          req_sel,
    input  logic [FLIT_W-1:0]   req_flit,
    input  logic                ready,
    output logic                overrun,
    wrap_enc_8b_10b_if.framer   fr_if
);

    logic accept;
    logic dropped;

    // ready alone decides, no other qualifier
    assign accept  = req_start & ready;
    // strobe while busy is lost
    assign dropped = req_start & ~ready;

    // start pulse, one cycle after the accepting edge
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fr_if.start <= 1'b0;
        end else begin
            fr_if.start <= accept;
        end
    end

    // overrun sticks until the next reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            overrun <= 1'b0;
        end else if (dropped) begin
            overrun <= 1'b1;
        end
    end

    // request payload
    always_ff @(posedge CLK) begin
        if (accept) begin
            fr_if.flit      <= req_flit;
            // undefined codes pass through and become a no-op downstream
            fr_if.comma_sel <= comma_sel_t'(req_sel);
        end
    end

endmodule

//--- wrap_enc_8b_10b.sv
`timescale 1ns/1ns

module wrap_enc_8b_10b import phy_pkg::*; (
    input  logic           CLK,
    input  logic           nRST,
    wrap_enc_8b_10b_if.enc enc_if
);

    // per-byte encoder outputs
    logic [SYM_W-1:0]  byte_sym [BYTES_PER_FLIT];
    // all five bytes encoded, byte 4 on top
    flit_enc_t         flit_norm;
    flit_enc_t         n_flit;
    comma_length_sel_t n_len;

    // comma, metadata symbol, then an all-ones pad
    function automatic flit_enc_t two_sym_word(input comma_t c, input logic [SYM_W-1:0] meta);
        flit_enc_t w;
        w.ctrl.comma     = c;
        w.ctrl.meta_data = meta;
        w.ctrl.pad       = '1;
        return w;
    endfunction

    for (genvar i = 0; i < BYTES_PER_FLIT; i++) begin : g_byte_enc
        enc_8b10b i_enc_8b10b (
            .data_in  (enc_if.flit[8*i +: 8]),
            .data_out (byte_sym[i])
        );
    end

    always_comb begin
        for (int i = 0; i < BYTES_PER_FLIT; i++) begin
            flit_norm.sym[i] = byte_sym[i];
        end
    end

    // comma word selection
    always_comb begin
        // no-op: all zero, one symbol
        n_flit = '0;
        n_len  = SELECT_COMMA_1_FLIT;
        case (enc_if.comma_sel)
            START_PACKET_SEL:   n_flit = {START_COMMA, {FLIT_W{1'b1}}};
            END_PACKET_SEL:     n_flit = {END_COMMA, {FLIT_W{1'b1}}};
            RESEND_PACKET0_SEL: n_flit = two_sym_word(RESEND_PACKET0_COMMA, flit_norm.ctrl.meta_data);
            RESEND_PACKET1_SEL: n_flit = two_sym_word(RESEND_PACKET1_COMMA, flit_norm.ctrl.meta_data);
            RESEND_PACKET2_SEL: n_flit = two_sym_word(RESEND_PACKET2_COMMA, flit_norm.ctrl.meta_data);
            RESEND_PACKET3_SEL: n_flit = two_sym_word(RESEND_PACKET3_COMMA, flit_norm.ctrl.meta_data);
            ACK_SEL:            n_flit = two_sym_word(ACK_COMMA, flit_norm.ctrl.meta_data);
            NACK_SEL:           n_flit = two_sym_word(NACK_COMMA, flit_norm.ctrl.meta_data);
            DATA_SEL:           n_flit = flit_norm;
            default:            n_flit = '0;
        endcase
        // length follows the kind of word
        case (enc_if.comma_sel)
            RESEND_PACKET0_SEL, RESEND_PACKET1_SEL, RESEND_PACKET2_SEL,
            RESEND_PACKET3_SEL, ACK_SEL, NACK_SEL: n_len = SELECT_COMMA_2_FLIT;
            DATA_SEL:                              n_len = SELECT_COMMA_DATA;
            default:                               n_len = SELECT_COMMA_1_FLIT;
        endcase
    end

    // start_out trails start by one cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            enc_if.start_out            <= 1'b0;
            enc_if.comma_length_sel_out <= SELECT_COMMA_1_FLIT;
        end else begin
            enc_if.start_out <= enc_if.start;
            if (enc_if.start) begin
                enc_if.comma_length_sel_out <= n_len;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (enc_if.start) begin
            enc_if.flit_out <= n_flit;
        end
    end

endmodule

//--- tx_symbol_serializer.sv
`timescale 1ns/1ns

module tx_symbol_serializer import phy_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    wrap_enc_8b_10b_if.ser    ser_if,
    output logic              ready,
    output logic [SYM_W-1:0]  sym,
    output logic              sym_valid,
    output logic              sym_first
);

    // holding slot, one word deep
    logic                  slot_full;
    flit_enc_t             slot_word;
    comma_length_sel_t     slot_len;

    // shifter, msb symbol on the line
    logic [ENC_FLIT_W-1:0] shift_q;
    // symbols still to send, 0 means idle
    logic [2:0]            cnt;
    logic                  first_q;

    logic                  can_load;
    logic                  load;
    logic                  slot_take;
    flit_enc_t             src_word;
    comma_length_sel_t     src_len;

    function automatic logic [2:0] sym_count(input comma_length_sel_t len);
        case (len)
            SELECT_COMMA_2_FLIT: return 3'd2;
            SELECT_COMMA_DATA:   return 3'(BYTES_PER_FLIT);
            default:             return 3'd1;
        endcase
    endfunction

    // shifter idle or on its last symbol
    assign can_load = (cnt <= 3'd1);
    assign load     = can_load & (slot_full | ser_if.start_out);

    // slot holds the older item, so it goes first
    assign src_word = slot_full ? slot_word : ser_if.flit_out;
    assign src_len  = slot_full ? slot_len : ser_if.comma_length_sel_out;

    // new word parks in the slot unless it went straight to the shifter
    assign slot_take = ser_if.start_out & ~(load & ~slot_full);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            slot_full <= 1'b0;
            cnt       <= 3'd0;
            first_q   <= 1'b0;
        end else begin
            if (slot_take) begin
                slot_full <= 1'b1;
            end else if (load) begin
                slot_full <= 1'b0;
            end
            if (load) begin
                cnt <= sym_count(src_len);
            end else if (cnt != 3'd0) begin
                cnt <= cnt - 3'd1;
            end
            // first symbol shows the cycle after the load
            first_q <= load;
        end
    end

    always_ff @(posedge CLK) begin
        if (slot_take) begin
            slot_word <= ser_if.flit_out;
            slot_len  <= ser_if.comma_length_sel_out;
        end
        if (load) begin
            shift_q <= src_word;
        end else if (cnt != 3'd0) begin
            shift_q <= {shift_q[ENC_FLIT_W-SYM_W-1:0], {SYM_W{1'b0}}};
        end
    end

    assign sym       = shift_q[ENC_FLIT_W-1 -: SYM_W];
    assign sym_valid = (cnt != 3'd0);
    assign sym_first = first_q;

    // nothing parked and nothing on its way in
    assign ready = ~slot_full & ~ser_if.start & ~ser_if.start_out;

endmodule

//--- chiplet_phy_tx.sv
`timescale 1ns/1ns

module chiplet_phy_tx import phy_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    // request side
    input  logic              req_start,
    input  logic [3:0]        req_sel,
    input  logic [FLIT_W-1:0] req_flit,
    output logic              ready,
    output logic              overrun,
    // line side
    output logic [SYM_W-1:0]  sym,
    output logic              sym_valid,
    output logic              sym_first
);

    // framer -> encoder -> serializer
    wrap_enc_8b_10b_if ph_if ();

    // stage 1, request register
    tx_flit_framer i_tx_flit_framer (
        .CLK       (CLK),
        .nRST      (nRST),
        .req_start (req_start),
        .req_sel   (req_sel),
        .req_flit  (req_flit),
        .ready     (ready),
        .overrun   (overrun),
        .fr_if     (ph_if.framer)
    );

    // stage 2, 8b/10b and comma word
    wrap_enc_8b_10b i_wrap_enc_8b_10b (
        .CLK    (CLK),
        .nRST   (nRST),
        .enc_if (ph_if.enc)
    );

    // stage 3, symbols out, ready back to the framer
    tx_symbol_serializer i_tx_symbol_serializer (
        .CLK       (CLK),
        .nRST      (nRST),
        .ser_if    (ph_if.ser),
        .ready     (ready),
        .sym       (sym),
        .sym_valid (sym_valid),
        .sym_first (sym_first)
    );

endmodule

//--- tb_phy_ref.svh
// 6b sub-block for negative running disparity in abcdei order
function automatic logic [5:0] ref_6b(input logic [4:0] x);
    logic [5:0] t [32];
    t = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
          6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
          6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
          6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011};
    return t[x];
endfunction

// 4b sub-block with the rd- codes flipped when the 6b block left rd positive
function automatic logic [3:0] ref_4b(input logic [2:0] y, input logic rd_pos, input logic alt);
    logic [3:0] t [8];
    logic [3:0] c;
    t = '{4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
    c = (y == 3'd7 && alt) ? 4'b0111 : t[y];
    // balanced codes match in both columns apart from x.3
    if (rd_pos && ($countones(c) != 2 || y == 3'd3)) begin
        c = ~c;
    end
    return c;
endfunction

function automatic logic [SYM_W-1:0] ref_byte(input logic [7:0] b);
    logic [5:0] c6;
    logic       rd_pos;
    logic       alt;
    c6     = ref_6b(b[4:0]);
    rd_pos = ($countones(c6) > 3);
    alt    = rd_pos ? (b[4:0] inside {11, 13, 14}) : (b[4:0] inside {17, 18, 20});
    return {c6, ref_4b(b[7:5], rd_pos, alt)};
endfunction

// K28.y from rd- where the 001111 block leaves rd positive and K28.7 takes A7
function automatic logic [SYM_W-1:0] ref_k28(input logic [3:0] sel);
    logic [2:0] y;
    case (sel)
        START_PACKET_SEL:   y = 3'd1;
        END_PACKET_SEL:     y = 3'd5;
        RESEND_PACKET0_SEL: y = 3'd0;
        RESEND_PACKET1_SEL: y = 3'd2;
        RESEND_PACKET2_SEL: y = 3'd3;
        RESEND_PACKET3_SEL: y = 3'd4;
        ACK_SEL:            y = 3'd6;
        default:            y = 3'd7;
    endcase
    return {6'b001111, ref_4b(y, 1'b1, 1'b1)};
endfunction

// symbols of one request in line order and how many there are
function automatic int ref_symbols(input logic [3:0] sel, input logic [FLIT_W-1:0] flit,
                                   output logic [BYTES_PER_FLIT-1:0][SYM_W-1:0] s);
    s = '0;
    if (sel == DATA_SEL) begin
        // byte 4 leaves first
        for (int i = 0; i < BYTES_PER_FLIT; i++) begin
            s[i] = ref_byte(flit[8*(BYTES_PER_FLIT-1-i) +: 8]);
        end
        return BYTES_PER_FLIT;
    end
    if (sel == START_PACKET_SEL || sel == END_PACKET_SEL) begin
        s[0] = ref_k28(sel);
        return 1;
    end
    if (sel <= NACK_SEL) begin
        s[0] = ref_k28(sel);
        s[1] = ref_byte(flit[8*META_BYTE +: 8]);
        return 2;
    end
    // undefined kind gives one zero symbol
    return 1;
endfunction

//--- tb_chiplet_phy_tx.sv
`timescale 1ns/1ns

module tb_chiplet_phy_tx import phy_pkg::*; ();

    logic              CLK;
    logic              nRST;
    logic              req_start;
    logic [3:0]        req_sel;
    logic [FLIT_W-1:0] req_flit;
    logic              ready;
    logic              overrun;
    logic [SYM_W-1:0]  sym;
    logic              sym_valid;
    logic              sym_first;

    // expected symbols in line order, first-of-item flag alongside
    logic [SYM_W-1:0]  exp_q [$];
    logic              first_q [$];
    // queue head as the assertions see it
    logic [SYM_W-1:0]  exp_sym;
    logic              exp_first;
    logic              exp_any;
    logic              prev_valid;
    int                errors;
    int                n_syms;
    int                n_b2b;
    int                seed;
    int                timeout_cyc = 40;

    `include "tb_phy_ref.svh"

    chiplet_phy_tx i_chiplet_phy_tx (.*);

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    // scoreboard, retire the symbol just sent and queue newly accepted requests
    always @(posedge CLK) begin
        logic [BYTES_PER_FLIT-1:0][SYM_W-1:0] s;
        int n;
        if (nRST) begin
            if (sym_valid && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(first_q.pop_front());
                n_syms++;
            end
            // item starting right after another one's last symbol
            if (sym_first && prev_valid) begin
                n_b2b++;
            end
            if (req_start && ready) begin
                n = ref_symbols(req_sel, req_flit, s);
                for (int i = 0; i < n; i++) begin
                    exp_q.push_back(s[i]);
                    first_q.push_back(i == 0);
                end
            end
        end
        prev_valid = sym_valid;
        exp_any    = (exp_q.size() > 0);
        exp_sym    = exp_any ? exp_q[0] : '0;
        exp_first  = exp_any ? first_q[0] : 1'b0;
    end

    a_sym_expected: assert property (@(posedge CLK) disable iff (!nRST) sym_valid |-> exp_any)
        else begin
            $display("symbol 0x%h sent while nothing was expected", $sampled(sym));
            errors++;
        end
    a_sym_value: assert property (@(posedge CLK) disable iff (!nRST)
                                  sym_valid && exp_any |-> sym == exp_sym)
        else begin
            $display("Mismatch sym: got 0x%h expected 0x%h", $sampled(sym), $sampled(exp_sym));
            errors++;
        end
    a_sym_first: assert property (@(posedge CLK) disable iff (!nRST)
                                  sym_valid && exp_any |-> sym_first == exp_first)
        else begin
            $display("Mismatch sym_first: got 0x%h expected 0x%h", $sampled(sym_first),
                     $sampled(exp_first));
            errors++;
        end
    // sticky until reset
    a_overrun_held: assert property (@(posedge CLK) disable iff (!nRST) overrun |=> overrun)
        else begin
            $display("overrun dropped back low without a reset");
            errors++;
        end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // wait for ready mid-cycle, then strobe for one cycle
    task automatic send_req(input logic [3:0] sel, input logic [FLIT_W-1:0] flit);
        int n;
        n = 0;
        @(negedge CLK);
        while (!ready && n < timeout_cyc) begin
            @(negedge CLK);
            n++;
        end
        if (!ready) begin
            $display("ready stayed low for %0d cycles before a request", n);
            errors++;
        end
        @(posedge CLK);
        req_start <= 1'b1;
        req_sel   <= sel;
        req_flit  <= flit;
        @(posedge CLK);
        req_start <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge CLK);
        while ((exp_q.size() > 0 || sym_valid) && n < timeout_cyc) begin
            @(negedge CLK);
            n++;
        end
        if (exp_q.size() > 0 || sym_valid) begin
            $display("%0d expected symbols never came out", exp_q.size());
            errors++;
        end
    endtask

    initial begin
        logic [3:0] sel;
        int n;
        seed       = 32'hc4cc;
        errors     = 0;
        n_syms     = 0;
        n_b2b      = 0;
        prev_valid = 1'b0;
        exp_any    = 1'b0;
        exp_sym    = '0;
        exp_first  = 1'b0;
        nRST       = 1'b0;
        req_start  = 1'b0;
        req_sel    = '0;
        req_flit   = '0;
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_val("ready", ready, 1);
        check_val("sym_valid", sym_valid, 0);
        check_val("overrun", overrun, 0);

        // data flit, bytes picked to hit the A7 codes
        send_req(DATA_SEL, 40'hf1_f2_f4_eb_ed);
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!sym_valid && n < timeout_cyc);
        check_val("first symbol delay", n, 3);
        wait_drain();

        // one-symbol and two-symbol control words
        for (int k = START_PACKET_SEL; k <= NACK_SEL; k++) begin
            send_req(4'(k), 40'($random(seed)) << 8 | 40'($random(seed)));
        end
        wait_drain();

        // random traffic, undefined kinds included
        repeat (60) begin
            sel = 4'($unsigned($random(seed)) % 10);
            send_req(sel, {8'($random(seed)), 32'($random(seed))});
        end
        wait_drain();
        check_val("overrun", overrun, 0);
        if (n_b2b == 0) begin
            $display("no two items were ever sent back to back");
            errors++;
        end

        // strobe while the encoder still holds the last item
        send_req(DATA_SEL, {8'($random(seed)), 32'($random(seed))});
        @(posedge CLK);
        req_start <= 1'b1;
        req_sel   <= ACK_SEL;
        @(negedge CLK);
        check_val("ready", ready, 0);
        @(posedge CLK);
        req_start <= 1'b0;
        @(negedge CLK);
        check_val("overrun", overrun, 1);
        wait_drain();

        send_req(4'hc, '1);
        wait_drain();
        check_val("overrun", overrun, 1);

        $display("%0d symbols checked, %0d errors", n_syms, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
phy_pkg.sv
enc_8b10b.sv
wrap_enc_8b_10b_if.sv
tx_flit_framer.sv
wrap_enc_8b_10b.sv
tx_symbol_serializer.sv
chiplet_phy_tx.sv
tb_chiplet_phy_tx.sv
